// File: design/icache_pkg.sv
/* Shared geometry, address field and fill packet types of the instruction cache.
   Imported by every design file that needs them. */

package icache_pkg;

  localparam int icache_ways           = 4;
  localparam int icache_sets           = 64;
  localparam int icache_words_per_line = 4;
  localparam int addr_width            = 32;
  localparam int word_width            = 32;

  // address split, from the low end
  localparam int byte_off_width = 2;
  localparam int woff_width     = $clog2(icache_words_per_line);
  localparam int index_width    = $clog2(icache_sets);
  localparam int tag_width      = addr_width - index_width - woff_width - byte_off_width;
  localparam int way_width      = $clog2(icache_ways);

  typedef logic [addr_width-1:0]  icache_addr_t;
  typedef logic [tag_width-1:0]   icache_tag_t;
  typedef logic [index_width-1:0] icache_index_t;
  typedef logic [woff_width-1:0]  icache_woff_t;
  typedef logic [way_width-1:0]   icache_way_t;
  typedef logic [word_width-1:0]  icache_word_t;

  // tree bits of one set
  localparam int plru_root  = 2;
  localparam int plru_left  = 1;
  localparam int plru_right = 0;

  typedef logic [2:0] icache_plru_t;

  typedef enum logic [1:0] {
    e_fill_data  = 2'b00,
    e_fill_tag   = 2'b01,
    e_fill_inval = 2'b10
  } icache_fill_op_e;

  typedef struct packed {
    logic [word_width-tag_width-1:0] rsvd;
    icache_tag_t                     tag;
  } icache_tag_entry_s;

  // read as a data word or a tag entry depending on the fill opcode
  typedef union packed {
    icache_word_t      data;
    icache_tag_entry_s tag_entry;
  } icache_fill_payload_u;

endpackage

// File: design/icache_fill_if.sv
/* Fill packet from the memory side to the tag and data arrays.
   A valid packet is written at the next clock edge, there is no handshake. */

interface icache_fill_if;
  import icache_pkg::*;

  logic                 fill_v;
  icache_fill_op_e      fill_op;
  icache_index_t        fill_index;
  icache_way_t          fill_way;
  icache_woff_t         fill_word;
  icache_fill_payload_u fill_payload;

  modport send (
    output fill_v, fill_op, fill_index, fill_way, fill_word, fill_payload
  );

  modport array (
    input fill_v, fill_op, fill_index, fill_way, fill_word, fill_payload
  );

endinterface

// File: design/icache_tag_array.sv
/* Tag store and per-set valid bits. Fill packets set a tag or invalidate a way,
   a lookup reads all ways of one set with the result registered. */

module icache_tag_array (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  icache_fill_if.array                                  fill,
  input  logic                                          rd_v_i,
  input  icache_pkg::icache_index_t                     rd_index_i,
  output icache_pkg::icache_tag_t [icache_pkg::icache_ways-1:0] tags_o,
  output logic [icache_pkg::icache_ways-1:0]            valid_o
);
  import icache_pkg::*;

  icache_tag_t [icache_ways-1:0]         tag_mem [icache_sets];
  logic [icache_sets-1:0][icache_ways-1:0] valid_r;

  logic [icache_ways-1:0] way_mask;
  logic                   tag_we;
  logic                   inval_we;

  assign way_mask = {{(icache_ways-1){1'b0}}, 1'b1} << fill.fill_way;
  assign tag_we   = fill.fill_v & (fill.fill_op == e_fill_tag);
  assign inval_we = fill.fill_v & (fill.fill_op == e_fill_inval);

  // tag storage, no reset
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < icache_ways; w++) begin
      if (tag_we && way_mask[w]) begin
        tag_mem[fill.fill_index][w] <= fill.fill_payload.tag_entry.tag;
      end
    end
    if (rd_v_i) begin
      tags_o  <= tag_mem[rd_index_i];
      valid_o <= valid_r[rd_index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else begin
      for (int w = 0; w < icache_ways; w++) begin
        if (tag_we && way_mask[w]) begin
          valid_r[fill.fill_index][w] <= 1'b1;
        end else if (inval_we && way_mask[w]) begin
          valid_r[fill.fill_index][w] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: design/icache_data_array.sv
/* Instruction words in four rotated banks. A fill writes one word into one bank,
   a lookup reads the same row of every bank so all ways come out at once. */

module icache_data_array (
  input  logic                                           clk_i,
  icache_fill_if.array                                   fill,
  input  logic                                           rd_v_i,
  input  icache_pkg::icache_index_t                      rd_index_i,
  input  icache_pkg::icache_woff_t                       rd_woff_i,
  output icache_pkg::icache_word_t [icache_pkg::icache_ways-1:0] banks_o
);
  import icache_pkg::*;

  localparam int row_width = index_width + woff_width;
  localparam int bank_rows = icache_sets * icache_words_per_line;

  icache_word_t bank_mem [icache_ways][bank_rows];

  logic                 data_we;
  icache_way_t          wr_bank;
  logic [row_width-1:0] wr_row;
  logic [row_width-1:0] rd_row;

  // word o of way w sits in bank w^o at row {index, o}
  assign data_we = fill.fill_v & (fill.fill_op == e_fill_data);
  assign wr_bank = fill.fill_way ^ fill.fill_word;
  assign wr_row  = {fill.fill_index, fill.fill_word};
  assign rd_row  = {rd_index_i, rd_woff_i};

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < icache_ways; b++) begin
      if (data_we && (wr_bank == way_width'(b))) begin
        bank_mem[b][wr_row] <= fill.fill_payload.data;
      end
      if (rd_v_i) begin
        banks_o[b] <= bank_mem[b][rd_row];
      end
    end
  end

endmodule

// File: design/icache_lru.sv
/* Pseudo-LRU tree per set. Hits from TV update the tree, the victim for the
   TV set is encoded combinationally with invalid ways taking priority. */

module icache_lru (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                upd_v_i,
  input  icache_pkg::icache_index_t           upd_index_i,
  input  icache_pkg::icache_way_t             upd_way_i,
  input  icache_pkg::icache_index_t           victim_index_i,
  input  logic [icache_pkg::icache_ways-1:0]  way_valid_i,
  output icache_pkg::icache_way_t             victim_way_o
);
  import icache_pkg::*;

  icache_plru_t [icache_sets-1:0] plru_r;

  icache_plru_t plru_cur;
  icache_way_t  tree_way;
  icache_way_t  invalid_way;
  logic         invalid_found;

  // hit points the tree away from the used way
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      plru_r <= '0;
    end else if (upd_v_i) begin
      plru_r[upd_index_i][plru_root] <= ~upd_way_i[1];
      if (upd_way_i[1]) begin
        plru_r[upd_index_i][plru_right] <= ~upd_way_i[0];
      end else begin
        plru_r[upd_index_i][plru_left] <= ~upd_way_i[0];
      end
    end
  end

  assign plru_cur = plru_r[victim_index_i];
  assign tree_way = plru_cur[plru_root] ? {1'b1, plru_cur[plru_right]}
                                        : {1'b0, plru_cur[plru_left]};

  // lowest invalid way
  always_comb begin
    invalid_found = 1'b0;
    invalid_way   = '0;
    for (int w = icache_ways - 1; w >= 0; w--) begin
      if (!way_valid_i[w]) begin
        invalid_found = 1'b1;
        invalid_way   = way_width'(w);
      end
    end
  end

  assign victim_way_o = invalid_found ? invalid_way : tree_way;

endmodule

// File: design/icache_pipeline.sv
/* Two-stage lookup: TL waits on the array reads, TV compares tags and returns the
   word or raises a line request. Also holds the request credits and miss tracker. */

module icache_pipeline #(
  parameter int num_credits_p = 2
) (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic                                           fetch_v_i,
  input  icache_pkg::icache_addr_t                       fetch_addr_i,
  output logic                                           fetch_ready_o,
  output logic                                           rd_v_o,
  output icache_pkg::icache_index_t                      rd_index_o,
  output icache_pkg::icache_woff_t                       rd_woff_o,
  input  icache_pkg::icache_tag_t [icache_pkg::icache_ways-1:0]  tags_i,
  input  logic [icache_pkg::icache_ways-1:0]             valid_i,
  input  icache_pkg::icache_word_t [icache_pkg::icache_ways-1:0] banks_i,
  output logic                                           upd_v_o,
  output icache_pkg::icache_index_t                      upd_index_o,
  output icache_pkg::icache_way_t                        upd_way_o,
  output icache_pkg::icache_index_t                      victim_index_o,
  output logic [icache_pkg::icache_ways-1:0]             way_valid_o,
  input  icache_pkg::icache_way_t                        victim_way_i,
  output icache_pkg::icache_word_t                       data_o,
  output logic                                           data_v_o,
  output logic                                           miss_o,
  output logic                                           req_v_o,
  output icache_pkg::icache_addr_t                       req_addr_o,
  output icache_pkg::icache_way_t                        req_way_o,
  input  logic                                           credit_return_i,
  input  logic                                           fill_done_i
);
  import icache_pkg::*;

  localparam int credit_width_lp = $clog2(num_credits_p + 1);
  localparam int index_lsb_lp    = byte_off_width + woff_width;
  localparam int tag_lsb_lp      = index_lsb_lp + index_width;

  logic                          tl_we;
  logic                          v_tl_r;
  icache_addr_t                  addr_tl_r;

  logic                          tv_adv;
  logic                          v_tv_r;
  icache_addr_t                  addr_tv_r;
  icache_tag_t [icache_ways-1:0] tags_tv_r;
  logic [icache_ways-1:0]        valid_tv_r;
  icache_word_t [icache_ways-1:0] banks_tv_r;

  icache_tag_t                   tag_tv;
  icache_index_t                 index_tv;
  icache_woff_t                  woff_tv;
  logic                          hit;
  icache_way_t                   hit_way;
  logic                          miss_tv;

  logic [credit_width_lp-1:0]    credits_r;
  logic                          miss_r;

  assign tl_we      = fetch_v_i & fetch_ready_o;
  assign rd_v_o     = tl_we;
  assign rd_index_o = fetch_addr_i[index_lsb_lp +: index_width];
  assign rd_woff_o  = fetch_addr_i[byte_off_width +: woff_width];

  // TL stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
    end else begin
      v_tl_r <= tl_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_we) begin
      addr_tl_r <= fetch_addr_i;
    end
  end

  // a TL entry behind a missing TV entry is dropped
  assign tv_adv = v_tl_r & ~miss_tv;

  // TV stage, holds a miss until a credit is there
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tv_r <= 1'b0;
    end else if (miss_tv) begin
      v_tv_r <= ~req_v_o;
    end else begin
      v_tv_r <= v_tl_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_adv) begin
      addr_tv_r  <= addr_tl_r;
      tags_tv_r  <= tags_i;
      valid_tv_r <= valid_i;
      banks_tv_r <= banks_i;
    end
  end

  assign tag_tv   = addr_tv_r[tag_lsb_lp +: tag_width];
  assign index_tv = addr_tv_r[index_lsb_lp +: index_width];
  assign woff_tv  = addr_tv_r[byte_off_width +: woff_width];

  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = icache_ways - 1; w >= 0; w--) begin
      if (valid_tv_r[w] && (tags_tv_r[w] == tag_tv)) begin
        hit     = 1'b1;
        hit_way = way_width'(w);
      end
    end
  end

  assign miss_tv  = v_tv_r & ~hit;
  assign data_v_o = v_tv_r & hit;
  assign data_o   = banks_tv_r[hit_way ^ woff_tv];

  assign upd_v_o        = data_v_o;
  assign upd_index_o    = index_tv;
  assign upd_way_o      = hit_way;
  assign victim_index_o = index_tv;
  assign way_valid_o    = valid_tv_r;

  assign req_v_o    = miss_tv & (credits_r != '0);
  assign req_addr_o = addr_tv_r;
  assign req_way_o  = victim_way_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_r <= credit_width_lp'(num_credits_p);
    end else begin
      credits_r <= credits_r - credit_width_lp'(req_v_o) + credit_width_lp'(credit_return_i);
    end
  end

  // miss tracker, open from request to fill_done
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_r <= 1'b0;
    end else begin
      miss_r <= req_v_o | (miss_r & ~fill_done_i);
    end
  end

  assign miss_o        = miss_r;
  assign fetch_ready_o = ~miss_tv & ~miss_r;

endmodule

// File: design/icache_top.sv
/* Instruction cache top level. Fetches enter on plain ports, misses leave as
   credit-based line requests and the memory side answers with fill packets. */

module icache_top #(
  parameter int num_credits_p = 2
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             fetch_v_i,
  input  icache_pkg::icache_addr_t         fetch_addr_i,
  output logic                             fetch_ready_o,
  output icache_pkg::icache_word_t         data_o,
  output logic                             data_v_o,
  output logic                             miss_o,
  output logic                             req_v_o,
  output icache_pkg::icache_addr_t         req_addr_o,
  output icache_pkg::icache_way_t          req_way_o,
  input  logic                             credit_return_i,
  input  logic                             fill_v_i,
  input  icache_pkg::icache_fill_op_e      fill_op_i,
  input  icache_pkg::icache_index_t        fill_index_i,
  input  icache_pkg::icache_way_t          fill_way_i,
  input  icache_pkg::icache_woff_t         fill_word_i,
  input  icache_pkg::icache_fill_payload_u fill_payload_i,
  input  logic                             fill_done_i
);
  import icache_pkg::*;

  logic                           rd_v;
  icache_index_t                  rd_index;
  icache_woff_t                   rd_woff;
  icache_tag_t [icache_ways-1:0]  tags;
  logic [icache_ways-1:0]         valid;
  icache_word_t [icache_ways-1:0] banks;
  logic                           upd_v;
  icache_index_t                  upd_index;
  icache_way_t                    upd_way;
  icache_index_t                  victim_index;
  logic [icache_ways-1:0]         way_valid;
  icache_way_t                    victim_way;

  icache_fill_if fill_bus ();

  assign fill_bus.fill_v       = fill_v_i;
  assign fill_bus.fill_op      = fill_op_i;
  assign fill_bus.fill_index   = fill_index_i;
  assign fill_bus.fill_way     = fill_way_i;
  assign fill_bus.fill_word    = fill_word_i;
  assign fill_bus.fill_payload = fill_payload_i;

  icache_tag_array tag_array (
    .clk_i, .reset_i, .fill(fill_bus.array),
    .rd_v_i(rd_v), .rd_index_i(rd_index), .tags_o(tags), .valid_o(valid)
  );

  icache_data_array data_array (
    .clk_i, .fill(fill_bus.array),
    .rd_v_i(rd_v), .rd_index_i(rd_index), .rd_woff_i(rd_woff), .banks_o(banks)
  );

  icache_lru lru (
    .clk_i, .reset_i,
    .upd_v_i(upd_v), .upd_index_i(upd_index), .upd_way_i(upd_way),
    .victim_index_i(victim_index), .way_valid_i(way_valid), .victim_way_o(victim_way)
  );

  icache_pipeline #(.num_credits_p(num_credits_p)) pipe (
    .clk_i, .reset_i, .fetch_v_i, .fetch_addr_i, .fetch_ready_o,
    .rd_v_o(rd_v), .rd_index_o(rd_index), .rd_woff_o(rd_woff),
    .tags_i(tags), .valid_i(valid), .banks_i(banks),
    .upd_v_o(upd_v), .upd_index_o(upd_index), .upd_way_o(upd_way),
    .victim_index_o(victim_index), .way_valid_o(way_valid), .victim_way_i(victim_way),
    .data_o, .data_v_o, .miss_o, .req_v_o, .req_addr_o, .req_way_o,
    .credit_return_i, .fill_done_i
  );

endmodule

// File: dv/icache_sva.sv
/* Port-level protocol checks on the instruction cache, bound into the top level. */

module icache_sva (
  input logic clk_i,
  input logic reset_i,
  input logic fill_v_i,
  input logic data_v_o,
  input logic req_v_o,
  input logic miss_o
);

  // fills only arrive while a line request is open
  fill_in_miss: assert property (@(posedge clk_i) disable iff (reset_i) fill_v_i |-> miss_o)
    else $error("fill packet while no miss is open");

  one_result: assert property (@(posedge clk_i) disable iff (reset_i) !(data_v_o && req_v_o))
    else $error("hit data and line request in the same cycle");

  req_then_miss: assert property (@(posedge clk_i) disable iff (reset_i) req_v_o |=> miss_o)
    else $error("miss_o not raised after a line request");

  idle_after_reset: assert property (@(posedge clk_i) reset_i |=> !req_v_o && !miss_o)
    else $error("request or miss active right after reset");

endmodule

bind icache_top icache_sva sva_i (
  .clk_i, .reset_i, .fill_v_i, .data_v_o, .req_v_o, .miss_o
);

// File: dv/icache_tb.sv
/* Testbench for the instruction cache. Drives fetches, answers line requests as the
   memory side and checks every result against a model of tags, valid and LRU bits. */

module icache_tb;
  import icache_pkg::*;

  localparam int timeout_cycles = 200;

  typedef struct packed {
    logic         hit;
    icache_way_t  way;
    icache_word_t word;
    icache_addr_t addr;
    int           due;
  } expect_s;

  logic                 clk_i = 1'b0;
  logic                 reset_i;
  logic                 fetch_v_i;
  icache_addr_t         fetch_addr_i;
  logic                 fetch_ready_o;
  icache_word_t         data_o;
  logic                 data_v_o;
  logic                 miss_o;
  logic                 req_v_o;
  icache_addr_t         req_addr_o;
  icache_way_t          req_way_o;
  logic                 credit_return_i;
  logic                 fill_v_i;
  icache_fill_op_e      fill_op_i;
  icache_index_t        fill_index_i;
  icache_way_t          fill_way_i;
  icache_woff_t         fill_word_i;
  icache_fill_payload_u fill_payload_i;
  logic                 fill_done_i;

  // reference model of the cache state
  icache_tag_t  m_tag [icache_sets][icache_ways];
  logic         m_valid [icache_sets][icache_ways];
  logic         m_root [icache_sets];
  logic         m_left [icache_sets];
  logic         m_right [icache_sets];

  expect_s      exp_q[$];
  expect_s      front;
  icache_addr_t issue_q[$];
  int           cycle = 0;
  int           last_miss_cycle = -10;
  int           credits_free = 2;
  int           seed = 14;

  icache_top #(.num_credits_p(2)) dut_i (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  // memory contents of a line, word by word
  function automatic icache_word_t line_word(input icache_addr_t addr, input icache_woff_t woff);
    return {addr[31:4], woff, 2'b11} ^ 32'h5ac3_0000;
  endfunction

  function automatic icache_addr_t make_addr(input icache_tag_t tag, input icache_index_t idx,
                                             input icache_woff_t woff);
    return {tag, idx, woff, 2'b00};
  endfunction

  function automatic expect_s predict(input icache_addr_t addr);
    expect_s       e;
    icache_index_t idx;
    logic          found;
    idx   = addr[9:4];
    e     = '0;
    found = 1'b0;
    e.addr = addr;
    for (int w = 0; w < icache_ways; w++) begin
      if (!e.hit && m_valid[idx][icache_way_t'(w)] &&
          m_tag[idx][icache_way_t'(w)] == addr[31:10]) begin
        e.hit = 1'b1;
        e.way = icache_way_t'(w);
      end
    end
    if (e.hit) begin
      e.word = line_word(addr, addr[3:2]);
    end else begin
      e.way = m_root[idx] ? {1'b1, m_right[idx]} : {1'b0, m_left[idx]};
      for (int w = 0; w < icache_ways; w++) begin
        if (!found && !m_valid[idx][icache_way_t'(w)]) begin
          found = 1'b1;
          e.way = icache_way_t'(w);
        end
      end
    end
    return e;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input icache_word_t got, input icache_word_t want);
    if (got !== want) begin
      report_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  task automatic check_way(input string name, input icache_way_t got, input icache_way_t want);
    if (got !== want) begin
      report_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  task automatic check_addr(input string name, input icache_addr_t got, input icache_addr_t want);
    if (got !== want) begin
      report_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  // runs in the cycle a fetch is taken, so the model follows DUT order
  task automatic accept_fetch(input icache_addr_t addr);
    expect_s       e;
    icache_index_t idx;
    idx = addr[9:4];
    // the fetch right behind a miss is squashed
    if (last_miss_cycle != cycle - 1) begin
      e = predict(addr);
      e.due = cycle + 2;
      if (e.hit) begin
        m_root[idx] = (e.way < 2'd2);
        if (e.way < 2'd2) begin
          m_left[idx] = ~e.way[0];
        end else begin
          m_right[idx] = ~e.way[0];
        end
      end else begin
        last_miss_cycle = cycle;
        // a miss waits in TV while no credit is left
        if (credits_free <= 0) begin
          e.due = -1;
        end
        credits_free--;
      end
      exp_q.push_back(e);
    end
  endtask

  task automatic issue_fetches();
    int waited;
    while (issue_q.size() != 0) begin
      @(posedge clk_i);
      fetch_v_i    <= 1'b1;
      fetch_addr_i <= issue_q[0];
      waited = 0;
      @(negedge clk_i);
      while (!fetch_ready_o) begin
        waited++;
        if (waited > timeout_cycles) report_error("fetch never accepted by the DUT");
        @(negedge clk_i);
      end
      accept_fetch(issue_q.pop_front());
    end
    @(posedge clk_i);
    fetch_v_i <= 1'b0;
  endtask

  task automatic wait_request(output icache_addr_t addr, output icache_way_t way);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!req_v_o) begin
      waited++;
      if (waited > timeout_cycles) report_error("no line request from the DUT");
      @(negedge clk_i);
    end
    addr = req_addr_o;
    way  = req_way_o;
  endtask

  // four data words, then the tag
  task automatic send_line(input icache_addr_t addr, input icache_way_t way);
    icache_fill_payload_u p;
    for (int w = 0; w <= icache_words_per_line; w++) begin
      @(posedge clk_i);
      p = '0;
      fill_v_i     <= 1'b1;
      fill_index_i <= addr[9:4];
      fill_way_i   <= way;
      fill_word_i  <= icache_woff_t'(w);
      if (w < icache_words_per_line) begin
        fill_op_i <= e_fill_data;
        p.data = line_word(addr, icache_woff_t'(w));
      end else begin
        fill_op_i <= e_fill_tag;
        p.tag_entry.tag = addr[31:10];
      end
      fill_payload_i <= p;
    end
    m_tag[addr[9:4]][way]   = addr[31:10];
    m_valid[addr[9:4]][way] = 1'b1;
  endtask

  task automatic send_inval(input icache_index_t idx, input icache_way_t way);
    @(posedge clk_i);
    fill_v_i     <= 1'b1;
    fill_op_i    <= e_fill_inval;
    fill_index_i <= idx;
    fill_way_i   <= way;
    m_valid[idx][way] = 1'b0;
  endtask

  task automatic finish_fill(input logic give_credit);
    @(posedge clk_i);
    fill_v_i        <= 1'b0;
    fill_done_i     <= 1'b1;
    credit_return_i <= give_credit;
    if (give_credit) begin
      credits_free++;
    end
    @(posedge clk_i);
    fill_done_i     <= 1'b0;
    credit_return_i <= 1'b0;
  endtask

  task automatic return_credit();
    @(posedge clk_i);
    credit_return_i <= 1'b1;
    credits_free++;
    @(posedge clk_i);
    credit_return_i <= 1'b0;
  endtask

  task automatic handle_miss(input logic give_credit, output icache_addr_t addr,
                             output icache_way_t way);
    wait_request(addr, way);
    send_line(addr, way);
    finish_fill(give_credit);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > timeout_cycles) report_error("expected results never came out of the DUT");
      @(negedge clk_i);
    end
  endtask

  // results leave in fetch order, one queue entry each
  always @(negedge clk_i) begin
    if (!reset_i && (data_v_o || req_v_o)) begin
      if (exp_q.size() == 0) begin
        report_error("result from the DUT with no fetch outstanding");
      end else begin
        front = exp_q.pop_front();
        if (data_v_o != front.hit) begin
          report_error($sformatf("Mismatch data_v_o: got 0x%h, expected 0x%h for address 0x%h",
                                 data_v_o, front.hit, front.addr));
        end else if (data_v_o) begin
          if (cycle != front.due) report_error("hit data not two cycles after its fetch");
          check_word("data_o", data_o, front.word);
        end else begin
          if (front.due >= 0 && cycle != front.due) begin
            report_error("line request not two cycles after its fetch");
          end
          check_addr("req_addr_o", req_addr_o, front.addr);
          check_way("req_way_o", req_way_o, front.way);
        end
      end
    end else if (!reset_i && exp_q.size() != 0 && exp_q[0].due >= 0 &&
                 cycle > exp_q[0].due) begin
      report_error("result missing two cycles after its fetch");
    end
  end

  initial begin : stimulus
    icache_tag_t  tags [icache_ways];
    icache_addr_t addr;
    icache_addr_t got_addr;
    icache_way_t  got_way;
    icache_way_t  gone_way;
    expect_s      guess;
    logic [31:0]  r;
    m_valid = '{default: '{default: 1'b0}};
    m_root  = '{default: 1'b0};
    m_left  = '{default: 1'b0};
    m_right = '{default: 1'b0};
    reset_i         <= 1'b1;
    fetch_v_i       <= 1'b0;
    fetch_addr_i    <= '0;
    credit_return_i <= 1'b0;
    fill_v_i        <= 1'b0;
    fill_op_i       <= e_fill_data;
    fill_index_i    <= '0;
    fill_way_i      <= '0;
    fill_word_i     <= '0;
    fill_payload_i  <= '0;
    fill_done_i     <= 1'b0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (!fetch_ready_o || data_v_o || req_v_o || miss_o) begin
      report_error("outputs not idle after reset");
    end

    // fill all ways of set 5, each miss takes the lowest invalid way
    for (int w = 0; w < icache_ways; w++) begin
      r = $random(seed);
      tags[icache_way_t'(w)] = r[21:0];
      addr = make_addr(r[21:0], 6'd5, icache_woff_t'(w));
      issue_q.push_back(addr);
      issue_fetches();
      handle_miss(1'b1, got_addr, got_way);
      check_way("req_way_o", got_way, icache_way_t'(w));
      issue_q.push_back(addr);
      issue_fetches();
      wait_drain();
    end

    // every way and word offset back to back, through the bank rotation
    for (int i = 0; i < 16; i++) begin
      issue_q.push_back(make_addr(tags[icache_way_t'(i % 4)], 6'd5, icache_woff_t'(i / 4)));
    end
    issue_fetches();
    wait_drain();

    // a hit right behind a miss is squashed and re-issued
    r = $random(seed);
    addr = make_addr(r[21:0], 6'd12, r[23:22]);
    issue_q.push_back(addr);
    issue_q.push_back(make_addr(tags[2], 6'd5, 2'd1));
    issue_fetches();
    handle_miss(1'b1, got_addr, got_way);
    issue_q.push_back(addr);
    issue_q.push_back(make_addr(tags[2], 6'd5, 2'd1));
    issue_fetches();
    wait_drain();

    // hits steer the tree, then a miss in the full set
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      issue_q.push_back(make_addr(tags[r[1:0]], 6'd5, r[3:2]));
    end
    issue_fetches();
    wait_drain();
    r = $random(seed);
    addr = make_addr(r[21:0], 6'd5, 2'd0);
    guess = predict(addr);
    gone_way = guess.way ^ 2'd1;
    issue_q.push_back(addr);
    issue_fetches();
    wait_request(got_addr, got_way);
    send_line(got_addr, got_way);
    send_inval(6'd5, gone_way);
    finish_fill(1'b1);
    r = $random(seed);
    issue_q.push_back(make_addr(r[21:0], 6'd5, 2'd3));
    issue_fetches();
    handle_miss(1'b1, got_addr, got_way);
    check_way("req_way_o", got_way, gone_way);
    wait_drain();

    // two misses keep their credits, the third has to wait
    for (int i = 0; i < 2; i++) begin
      r = $random(seed);
      issue_q.push_back(make_addr(r[21:0], icache_index_t'(20 + i), 2'd0));
      issue_fetches();
      handle_miss(1'b0, got_addr, got_way);
    end
    r = $random(seed);
    addr = make_addr(r[21:0], 6'd30, 2'd2);
    issue_q.push_back(addr);
    issue_fetches();
    // fetch still in TL here
    @(negedge clk_i);
    repeat (6) begin
      @(negedge clk_i);
      if (req_v_o || fetch_ready_o) report_error("request or ready raised with no credit left");
    end
    return_credit();
    handle_miss(1'b1, got_addr, got_way);
    check_addr("req_addr_o", got_addr, addr);
    return_credit();
    issue_q.push_back(addr);
    issue_fetches();
    wait_drain();

    $display("sim passed");
    $finish;
  end

endmodule

// File: filelist.f
design/icache_pkg.sv
design/icache_fill_if.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_lru.sv
design/icache_pipeline.sv
design/icache_top.sv
dv/icache_sva.sv
dv/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator and runs it; the exit status is the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module icache_tb \
  -Mdir build -o icache_sim -f filelist.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned status $status"
  exit $status
fi

./build/icache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi
exit 0
